// ==== vlog.f ====
src/mips_pkg.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_decode.sv
src/mips_syscall.sv
src/mips_core.sv
verif/tb_mips_core.sv

// ==== Makefile ====
# Verilator build and run of the MIPS core testbench

SIM = obj_dir/Vtb_mips_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

$(SIM): vlog.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_mips_core -Mdir obj_dir -f vlog.f

test: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "All tests passed!" sim.log || (echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/1ns

module tb_mips_core;

  // operands for the arithmetic block
  localparam int val_a = 1234;
  localparam int val_b = -567;
  localparam int r_t0 = 8;
  localparam int r_t1 = 9;
  // subroutine parked past the end of the main program
  localparam int sub_word = 56;
  localparam logic [31:0] lcg_mul = 32'd1103515245;
  localparam logic [31:0] lcg_inc = 32'd12345;
  localparam logic [31:0] lcg_seed = 32'd41860;
  localparam int req_timeout = 200;
  localparam int ack_timeout = 50;
  localparam int halt_timeout = 100;
  localparam int quiet_cycles = 50;
  localparam logic [31:0] syscall_word = {mips_pkg::op_rtype, 20'd0, mips_pkg::fn_syscall};

  logic clk;
  logic rst;
  logic [31:0] instr;
  logic out_ack;
  logic [31:0] instr_addr;
  logic out_req;
  logic [31:0] out_data;
  logic halted;

  // program rom and the expected print sequence
  logic [31:0] rom [64];
  int prog_len;
  logic [31:0] expected_q[$];
  string names_q[$];
  logic [31:0] lcg_state;
  int errors;

  mips_core dut0 (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .out_ack    (out_ack),
    .instr_addr (instr_addr),
    .out_req    (out_req),
    .out_data   (out_data),
    .halted     (halted)
  );

  // rom answers in the same cycle
  assign instr = rom[instr_addr[7:2]];

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                        input logic [5:0] fn);
    return {mips_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // absolute byte address with the upper pc bits zero
  function automatic logic [31:0] enc_j(input logic [5:0] op, input int byte_addr);
    return {op, 26'(byte_addr >> 2)};
  endfunction

  // ack delay of 0 to 7 cycles
  function automatic logic [2:0] next_delay();
    lcg_state = lcg_state * lcg_mul + lcg_inc;
    return lcg_state[18:16];
  endfunction

  task automatic put(input logic [31:0] word);
    rom[6'(prog_len)] = word;
    prog_len++;
  endtask

  task automatic expect_print(input logic [31:0] value, input string name);
    expected_q.push_back(value);
    names_q.push_back(name);
  endtask

  // result into a0 and print it
  task automatic print_r(input int rs, input int rt, input logic [5:0] fn,
                         input logic [31:0] value, input string name);
    put(enc_r(rs, rt, mips_pkg::reg_a0, fn));
    put(syscall_word);
    expect_print(value, name);
  endtask

  task automatic print_i(input logic [5:0] op, input int rs, input int imm,
                         input logic [31:0] value, input string name);
    put(enc_i(op, rs, mips_pkg::reg_a0, imm));
    put(syscall_word);
    expect_print(value, name);
  endtask

  // two words that must never run
  task automatic dead_print();
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_a0, 'hbad));
    put(syscall_word);
  endtask

  task automatic build_program();
    int k;
    int jal_addr;
    // unused words are addi to r0 tagged with their index
    for (k = 0; k < 64; k++) begin
      rom[6'(k)] = enc_i(mips_pkg::op_addi, 0, 0, k);
    end
    prog_len = 0;
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_v0, mips_pkg::sys_print_int));
    put(enc_i(mips_pkg::op_addi, 0, r_t0, val_a));
    put(enc_i(mips_pkg::op_addi, 0, r_t1, val_b));
    print_r(r_t0, r_t1, mips_pkg::fn_add, 32'(val_a + val_b), "add");
    print_r(r_t0, r_t1, mips_pkg::fn_sub, 32'(val_a - val_b), "sub");
    print_r(r_t0, r_t1, mips_pkg::fn_and, 32'(val_a & val_b), "and");
    print_r(r_t0, r_t1, mips_pkg::fn_or, 32'(val_a | val_b), "or");
    // logical immediates zero extend
    print_i(mips_pkg::op_andi, r_t1, 'hf0f0, 32'(val_b) & 32'h0000f0f0, "andi");
    print_i(mips_pkg::op_ori, r_t1, 'h1234, 32'(val_b) | 32'h00001234, "ori");
    print_i(mips_pkg::op_lui, 0, 'habcd, {16'habcd, 16'h0000}, "lui");
    print_r(r_t1, r_t0, mips_pkg::fn_slt, {31'd0, val_b < val_a}, "slt negative");
    print_r(r_t0, r_t1, mips_pkg::fn_slt, {31'd0, val_a < val_b}, "slt positive");
    // write to r0 must vanish
    put(enc_i(mips_pkg::op_addi, 0, 0, 99));
    print_i(mips_pkg::op_addi, 0, 7, 32'd7, "r0 plus constant");
    print_r(0, 0, mips_pkg::fn_add, 32'd0, "r0 plus r0");
    // branch offsets count words from pc plus 4
    put(enc_i(mips_pkg::op_beq, r_t0, r_t0, 2));
    dead_print();
    put(enc_i(mips_pkg::op_beq, r_t0, r_t1, 2));
    print_i(mips_pkg::op_addi, 0, 'h111, 32'h111, "beq not taken");
    put(enc_i(mips_pkg::op_bne, r_t0, r_t1, 2));
    dead_print();
    put(enc_j(mips_pkg::op_j, (prog_len + 3) * 4));
    dead_print();
    print_i(mips_pkg::op_addi, 0, 'h222, 32'h222, "after bne and j");
    // subroutine prints ra and returns here
    jal_addr = prog_len * 4;
    put(enc_j(mips_pkg::op_jal, sub_word * 4));
    expect_print(32'(jal_addr + 4), "ra from jal");
    print_i(mips_pkg::op_addi, 0, 'h333, 32'h333, "return by jr");
    // unknown service emits nothing
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_v0, 5));
    put(syscall_word);
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_v0, mips_pkg::sys_print_int));
    print_i(mips_pkg::op_addi, 0, 'h444, 32'h444, "after no-op syscall");
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_v0, mips_pkg::sys_exit));
    put(syscall_word);
    // print code past exit that never runs
    put(enc_i(mips_pkg::op_addi, 0, mips_pkg::reg_v0, mips_pkg::sys_print_int));
    dead_print();
    prog_len = sub_word;
    put(enc_r(mips_pkg::reg_ra, 0, mips_pkg::reg_a0, mips_pkg::fn_add));
    put(syscall_word);
    put(enc_r(mips_pkg::reg_ra, 0, 0, mips_pkg::fn_jr));
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_req(input logic level, input int limit, output logic ok);
    int cycles;
    cycles = 0;
    while (out_req !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    ok = (out_req === level);
  endtask

  task automatic wait_halted(input int limit, output logic ok);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    ok = (halted === 1'b1);
  endtask

  // four-phase responder with random gaps
  task automatic respond(input logic [31:0] held, output logic ok);
    int gap;
    gap = int'(next_delay());
    repeat (gap) @(negedge clk);
    check_value(out_data, held, "out_data held until ack");
    out_ack = 1'b1;
    wait_req(1'b0, ack_timeout, ok);
    gap = int'(next_delay());
    repeat (gap) @(negedge clk);
    out_ack = 1'b0;
  endtask

  initial begin
    int i;
    int errors_before;
    int tests_run;
    int tests_failed;
    logic ok;
    logic timed_out;
    logic extra_req;
    logic [31:0] seen;
    logic [31:0] frozen_pc;
    rst = 1'b1;
    out_ack = 1'b0;
    lcg_state = lcg_seed;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    build_program();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_value(32'({out_req, halted}), 32'd0, "req and halted low after reset");
    check_value(instr_addr, 32'd0, "pc after reset");

    i = 0;
    while (i < expected_q.size() && !timed_out) begin
      errors_before = errors;
      tests_run++;
      wait_req(1'b1, req_timeout, ok);
      if (!ok) begin
        $display("timeout: no output request for print %0d (%s)", i, names_q[i]);
        timed_out = 1'b1;
      end else begin
        seen = out_data;
        check_value(seen, expected_q[i], names_q[i]);
        respond(seen, ok);
        if (!ok) begin
          $display("timeout: out_req stayed high after ack for print %0d", i);
          timed_out = 1'b1;
        end
      end
      if (errors != errors_before || timed_out) begin
        tests_failed++;
      end
      $display("test %0d %s: %s", i, names_q[i],
               (errors == errors_before && !timed_out) ? "ok" : "FAILED");
      i++;
    end

    // exit must freeze the core with no further output
    if (!timed_out) begin
      errors_before = errors;
      tests_run++;
      wait_halted(halt_timeout, ok);
      if (!ok) begin
        $display("timeout: core never raised halted after the exit syscall");
        timed_out = 1'b1;
      end else begin
        frozen_pc = instr_addr;
        extra_req = 1'b0;
        repeat (quiet_cycles) begin
          @(negedge clk);
          if (out_req) begin
            extra_req = 1'b1;
          end
        end
        check_value(32'(halted), 32'd1, "halted stays high");
        check_value(32'(extra_req), 32'd0, "no out_req after exit");
        check_value(instr_addr, frozen_pc, "pc frozen after exit");
      end
      if (errors != errors_before || timed_out) begin
        tests_failed++;
      end
      $display("test %0d exit: %s", i,
               (errors == errors_before && !timed_out) ? "ok" : "FAILED");
    end

    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== src/mips_core.sv ====
`timescale 1ns/1ns

module mips_core (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [mips_pkg::data_w-1:0] instr,
  input  logic                        out_ack,
  output logic [mips_pkg::data_w-1:0] instr_addr,
  output logic                        out_req,
  output logic [mips_pkg::data_w-1:0] out_data,
  output logic                        halted
);

  logic [mips_pkg::data_w-1:0]     pc;
  logic [mips_pkg::data_w-1:0]     pc_plus4;
  logic [mips_pkg::data_w-1:0]     branch_target;
  logic [mips_pkg::data_w-1:0]     jump_target;
  logic [mips_pkg::data_w-1:0]     next_pc;

  // decode outputs
  logic [mips_pkg::alu_op_w-1:0]   alu_op;
  logic                            alu_src_imm;
  logic [mips_pkg::data_w-1:0]     imm;
  logic                            dec_reg_write;
  logic                            dst_rt;
  logic                            dec_jal;
  logic                            branch_eq;
  logic                            branch_ne;
  logic                            jump;
  logic                            jump_reg;
  logic                            syscall;

  // datapath
  logic [mips_pkg::reg_addr_w-1:0] rs;
  logic [mips_pkg::reg_addr_w-1:0] rt;
  logic [mips_pkg::reg_addr_w-1:0] rd;
  logic [mips_pkg::reg_addr_w-1:0] write_reg;
  logic [mips_pkg::data_w-1:0]     write_data;
  logic [mips_pkg::data_w-1:0]     read1;
  logic [mips_pkg::data_w-1:0]     read2;
  logic [mips_pkg::data_w-1:0]     v0;
  logic [mips_pkg::data_w-1:0]     a0;
  logic [mips_pkg::data_w-1:0]     alu_b;
  logic [mips_pkg::data_w-1:0]     alu_result;
  logic                            alu_zero;
  logic                            stall;
  logic                            hold;
  logic                            reg_write;
  logic                            jal;

  assign instr_addr = pc;

  // register fields
  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];

  // no state change while a syscall is pending or after exit
  assign hold      = stall || halted;
  assign reg_write = dec_reg_write && !hold;
  assign jal       = dec_jal && !hold;

  assign write_reg  = dst_rt ? rt : rd;
  assign write_data = dec_jal ? pc_plus4 : alu_result;
  assign alu_b      = alu_src_imm ? imm : read2;

  // targets relative to the following instruction
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    if (jump_reg) begin
      next_pc = read1;
    end else if (jump) begin
      next_pc = jump_target;
    end else if ((branch_eq && alu_zero) || (branch_ne && !alu_zero)) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!hold) begin
      pc <= next_pc;
    end
  end

  mips_decode decode0 (
    .instr       (instr),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .imm         (imm),
    .reg_write   (dec_reg_write),
    .dst_rt      (dst_rt),
    .jal         (dec_jal),
    .branch_eq   (branch_eq),
    .branch_ne   (branch_ne),
    .jump        (jump),
    .jump_reg    (jump_reg),
    .syscall     (syscall)
  );

  mips_regfile regfile0 (
    .clk        (clk),
    .rst        (rst),
    .jal        (jal),
    .reg_write  (reg_write),
    .rs         (rs),
    .rt         (rt),
    .write_reg  (write_reg),
    .write_data (write_data),
    .read1      (read1),
    .read2      (read2),
    .v0         (v0),
    .a0         (a0)
  );

  mips_alu alu0 (
    .a      (read1),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  mips_syscall syscall0 (
    .clk      (clk),
    .rst      (rst),
    .syscall  (syscall),
    .v0       (v0),
    .a0       (a0),
    .out_ack  (out_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .stall    (stall),
    .halted   (halted)
  );

endmodule

// ==== src/mips_syscall.sv ====
`timescale 1ns/1ns

module mips_syscall (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        syscall,
  input  logic [mips_pkg::data_w-1:0] v0,
  input  logic [mips_pkg::data_w-1:0] a0,
  input  logic                        out_ack,
  output logic                        out_req,
  output logic [mips_pkg::data_w-1:0] out_data,
  output logic                        stall,
  output logic                        halted
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_release
  } state_t;

  state_t state;
  logic   start_print;
  logic   start_exit;

  // services only start from idle and never after exit
  assign start_print = (state == st_idle) && syscall && !halted &&
                       (v0 == mips_pkg::sys_print_int);
  assign start_exit  = (state == st_idle) && syscall && !halted &&
                       (v0 == mips_pkg::sys_exit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      out_req <= 1'b0;
      halted  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start_print) begin
            state   <= st_request;
            out_req <= 1'b1;
          end
        end
        st_request: begin
          // ack seen, drop req
          if (out_ack) begin
            state   <= st_release;
            out_req <= 1'b0;
          end
        end
        st_release: begin
          // wait for ack to fall
          if (!out_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      // exit latch, only rst clears it
      if (start_exit) begin
        halted <= 1'b1;
      end
    end
  end

  // capture a0 once per print
  always_ff @(posedge clk) begin
    if (start_print) begin
      out_data <= a0;
    end
  end

  // hold the syscall in place until the handshake closes
  always_comb begin
    case (state)
      st_idle:    stall = start_print || start_exit;
      st_request: stall = 1'b1;
      st_release: stall = out_ack;
      default:    stall = 1'b0;
    endcase
  end

  a_data_stable: assert property (
    @(posedge clk) disable iff (rst) out_req |=> !out_req || $stable(out_data)
  );

  a_no_req_halted: assert property (
    @(posedge clk) disable iff (rst) (halted && !out_req) |=> !out_req
  );

endmodule

// ==== src/mips_decode.sv ====
`timescale 1ns/1ns

module mips_decode (
  input  logic [mips_pkg::data_w-1:0]   instr,
  output logic [mips_pkg::alu_op_w-1:0] alu_op,
  output logic                          alu_src_imm,
  output logic [mips_pkg::data_w-1:0]   imm,
  output logic                          reg_write,
  output logic                          dst_rt,
  output logic                          jal,
  output logic                          branch_eq,
  output logic                          branch_ne,
  output logic                          jump,
  output logic                          jump_reg,
  output logic                          syscall
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic [mips_pkg::data_w-1:0] imm_sext;
  logic [mips_pkg::data_w-1:0] imm_zext;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // two flavours of the 16-bit immediate
  assign imm_sext = {{16{instr[15]}}, instr[15:0]};
  assign imm_zext = {16'h0000, instr[15:0]};

  always_comb begin
    // defaults give a no-op
    alu_op      = mips_pkg::alu_add;
    alu_src_imm = 1'b0;
    imm         = imm_sext;
    reg_write   = 1'b0;
    dst_rt      = 1'b0;
    jal         = 1'b0;
    branch_eq   = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    jump_reg    = 1'b0;
    syscall     = 1'b0;
    case (opcode)
      mips_pkg::op_rtype: begin
        // rd destination
        case (funct)
          mips_pkg::fn_add: begin
            alu_op    = mips_pkg::alu_add;
            reg_write = 1'b1;
          end
          mips_pkg::fn_sub: begin
            alu_op    = mips_pkg::alu_sub;
            reg_write = 1'b1;
          end
          mips_pkg::fn_and: begin
            alu_op    = mips_pkg::alu_and;
            reg_write = 1'b1;
          end
          mips_pkg::fn_or: begin
            alu_op    = mips_pkg::alu_or;
            reg_write = 1'b1;
          end
          mips_pkg::fn_slt: begin
            alu_op    = mips_pkg::alu_slt;
            reg_write = 1'b1;
          end
          mips_pkg::fn_jr:      jump_reg = 1'b1;
          mips_pkg::fn_syscall: syscall  = 1'b1;
          default: ;
        endcase
      end
      mips_pkg::op_addi: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        dst_rt      = 1'b1;
      end
      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_lui: begin
        // logical immediates are zero extended
        imm         = imm_zext;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        dst_rt      = 1'b1;
        if (opcode == mips_pkg::op_andi) begin
          alu_op = mips_pkg::alu_and;
        end else if (opcode == mips_pkg::op_ori) begin
          alu_op = mips_pkg::alu_or;
        end else begin
          alu_op = mips_pkg::alu_lui;
        end
      end
      mips_pkg::op_beq: begin
        alu_op    = mips_pkg::alu_sub;
        branch_eq = 1'b1;
      end
      mips_pkg::op_bne: begin
        alu_op    = mips_pkg::alu_sub;
        branch_ne = 1'b1;
      end
      mips_pkg::op_j: jump = 1'b1;
      mips_pkg::op_jal: begin
        // link write handled by the regfile jal path
        jump = 1'b1;
        jal  = 1'b1;
      end
      default: ;
    endcase
  end

  // next-pc sources stay mutually exclusive
  always_comb begin
    a_pc_src_onehot: assert final ($onehot0({jump, jump_reg, branch_eq, branch_ne}));
  end

endmodule

// ==== src/mips_regfile.sv ====
`timescale 1ns/1ns

module mips_regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            jal,
  input  logic                            reg_write,
  input  logic [mips_pkg::reg_addr_w-1:0] rs,
  input  logic [mips_pkg::reg_addr_w-1:0] rt,
  input  logic [mips_pkg::reg_addr_w-1:0] write_reg,
  input  logic [mips_pkg::data_w-1:0]     write_data,
  output logic [mips_pkg::data_w-1:0]     read1,
  output logic [mips_pkg::data_w-1:0]     read2,
  output logic [mips_pkg::data_w-1:0]     v0,
  output logic [mips_pkg::data_w-1:0]     a0
);

  // 32 general purpose registers
  logic [mips_pkg::data_w-1:0] mem [1 << mips_pkg::reg_addr_w];

  // writes land on the rising edge
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << mips_pkg::reg_addr_w); i++) begin
        mem[i] <= '0;
      end
    end else if (jal) begin
      // link address goes to ra
      mem[mips_pkg::reg_ra] <= write_data;
    end else if (reg_write && write_reg != '0) begin
      // $zero silently drops writes
      mem[write_reg] <= write_data;
    end
  end

  // combinational reads, r0 hardwired
  assign read1 = (rs == '0) ? '0 : mem[rs];
  assign read2 = (rt == '0) ? '0 : mem[rt];

  // taps for the syscall unit
  assign v0 = mem[mips_pkg::reg_v0];
  assign a0 = mem[mips_pkg::reg_a0];

  // decode never asks for both a link write and a normal write
  a_jal_excl: assert property (
    @(posedge clk) disable iff (rst) !(jal && reg_write)
  );

endmodule

// ==== src/mips_alu.sv ====
`timescale 1ns/1ns

module mips_alu (
  input  logic [mips_pkg::data_w-1:0]   a,
  input  logic [mips_pkg::data_w-1:0]   b,
  input  logic [mips_pkg::alu_op_w-1:0] alu_op,
  output logic [mips_pkg::data_w-1:0]   result,
  output logic                          zero
);

  always_comb begin
    case (alu_op)
      mips_pkg::alu_add: result = a + b;
      // also the branch compare
      mips_pkg::alu_sub: result = a - b;
      mips_pkg::alu_and: result = a & b;
      mips_pkg::alu_or:  result = a | b;
      mips_pkg::alu_slt: begin
        // signed compare, 0 or 1
        result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      end
      mips_pkg::alu_lui: begin
        // immediate into the upper half, a ignored
        result = {b[15:0], 16'h0000};
      end
      default: result = '0;
    endcase
  end

  // equal operands after sub
  assign zero = (result == '0);

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

  // word and register index widths
  localparam int data_w = 32;
  localparam int reg_addr_w = 5;

  // fixed register indices used by the core
  localparam int reg_v0 = 2;
  localparam int reg_a0 = 4;
  localparam int reg_ra = 31;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;

  // funct field for r-type, instr[5:0]
  localparam logic [5:0] fn_jr      = 6'h08;
  localparam logic [5:0] fn_syscall = 6'h0c;
  localparam logic [5:0] fn_add     = 6'h20;
  localparam logic [5:0] fn_sub     = 6'h22;
  localparam logic [5:0] fn_and     = 6'h24;
  localparam logic [5:0] fn_or      = 6'h25;
  localparam logic [5:0] fn_slt     = 6'h2a;

  // alu selector
  localparam int alu_op_w = 3;
  localparam logic [alu_op_w-1:0] alu_add = 3'd0;
  localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
  localparam logic [alu_op_w-1:0] alu_and = 3'd2;
  localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
  localparam logic [alu_op_w-1:0] alu_slt = 3'd4;
  localparam logic [alu_op_w-1:0] alu_lui = 3'd5;

  // syscall services, matched against v0
  localparam logic [data_w-1:0] sys_print_int = 32'd1;
  localparam logic [data_w-1:0] sys_exit      = 32'd10;

endpackage
